// File: Bender.yml
package:
  name: ctrl_slice

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ctrl_pkg.sv
      - verilog/branch_cond.sv
      - verilog/pshpul_seq.sv
      - verilog/ucode_seq.sv
      - verilog/pc_unit.sv
      - verilog/ctrl_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/ctrl_checker.sv
      - tests/ctrl_tb.sv

// File: all.f
+incdir+verilog
verilog/ctrl_pkg.sv
verilog/branch_cond.sv
verilog/pshpul_seq.sv
verilog/ucode_seq.sv
verilog/pc_unit.sv
verilog/ctrl_top.sv
tests/ctrl_checker.sv
tests/ctrl_tb.sv

// File: tests/ctrl_checker.sv
// protocol assertions for the control slice, bound onto ctrl_top
// err_count holds the number of failed assertions
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module ctrl_checker(
    input                        clk,
    input                        rst,
    input                        cen,
    input                        halt,
    input                        op_ld,
    input                        busy,
    input ctrl_pkg::useq_state_t state,
    input                        ni,
    input                        stk_wr,
    input                        stk_rd,
    input [`CTRL_PC_W-1:0]       pc
);

import ctrl_pkg::*;

int err_count = 0;

// one edge after reset everything is back at rest
a_reset: assert property (@(posedge clk)
    rst |=> (pc == '0 && !ni && !busy && !stk_wr && !stk_rd))
    else begin $error("outputs not at rest after reset"); err_count++; end

// a stack cycle is either a write or a read
a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
    !(stk_wr && stk_rd))
    else begin $error("stk_wr and stk_rd high together"); err_count++; end

// ni lasts a single enabled cycle
a_ni_pulse: assert property (@(posedge clk) disable iff (rst)
    ni && cen |=> !ni)
    else begin $error("ni longer than one cycle"); err_count++; end

// a running instruction is never restarted by op_ld
// dispatch left out, halt may hold the sequencer there
a_no_accept_busy: assert property (@(posedge clk) disable iff (rst)
    op_ld && busy && cen && state != USEQ_DISPATCH |=> state != USEQ_DISPATCH)
    else begin $error("op_ld accepted while busy"); err_count++; end

// an idle sequencer ignores op_ld under halt
a_halt_idle: assert property (@(posedge clk) disable iff (rst)
    op_ld && halt && !busy && cen |=> !busy)
    else begin $error("op_ld taken while halt high"); err_count++; end

endmodule

bind ctrl_top ctrl_checker chk0(
    .clk    ( clk             ),
    .rst    ( rst             ),
    .cen    ( cen             ),
    .halt   ( halt            ),
    .op_ld  ( op_ld           ),
    .busy   ( busy            ),
    .state  ( u_ucode.state   ),
    .ni     ( ni              ),
    .stk_wr ( stk_wr          ),
    .stk_rd ( stk_rd          ),
    .pc     ( pc              )
);

// File: tests/ctrl_tb.sv
// testbench for ctrl_top, a reference model of pc and stack strobes
// runs nop, bcc, jmp, push/pull, freeze and reset scenarios
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module ctrl_tb;

import ctrl_pkg::*;

localparam time PERIOD  = 100;
localparam int  N_INSTR = 70;
// longest case is a full list plus a freeze
localparam int  MAX_LEN = 24;
localparam time TIMEOUT = N_INSTR * MAX_LEN * PERIOD + 20 * PERIOD;
localparam logic [31:0] SEED = 32'h8c32_add2;

logic                  clk = 1'b0;
logic                  rst;
logic                  cen;
logic                  op_ld;
logic [7:0]            op;
logic [7:0]            postbyte;
logic [`CTRL_PC_W-1:0] data;
logic [7:0]            cc;
logic                  halt;
logic [`CTRL_PC_W-1:0] pc;
logic                  ni;
logic                  busy;
logic                  stk_wr;
logic                  stk_rd;
stk_reg_t              stk_reg;
logic                  stk_hi;
logic                  stk_u;

logic [31:0]           lfsr = SEED;
logic [`CTRL_PC_W-1:0] exp_pc;
// {rd, u, hi, reg}
logic [5:0]            exp_q[$];
int                    ni_count = 0;
int                    ni_base;
// what the last edge did
logic                  stk_step;
logic                  cpu_step;
logic                  was_rst;
logic [22:0]           prev_out;
logic [22:0]           cur_out;

ctrl_top dut0(
    .clk(clk), .rst(rst), .cen(cen), .op_ld(op_ld), .op(op),
    .postbyte(postbyte), .data(data), .cc(cc), .halt(halt),
    .pc(pc), .ni(ni), .busy(busy), .stk_wr(stk_wr), .stk_rd(stk_rd),
    .stk_reg(stk_reg), .stk_hi(stk_hi), .stk_u(stk_u)
);

always #(PERIOD / 2) clk = ~clk;

task automatic die(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic mismatch(input string name, input logic [31:0] expv, input logic [31:0] actv);
    die($sformatf("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, expv, actv));
endtask

// galois lfsr, one step per bit taken
task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        v    = {v[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
    end
endtask

// 6809 short branch table
function automatic logic taken_ref(input logic [7:0] o, input logic [7:0] f);
    logic c;
    logic v;
    logic z;
    logic n;
    c = f[`CC_C];
    v = f[`CC_V];
    z = f[`CC_Z];
    n = f[`CC_N];
    case (o[3:0])
        4'h0: return 1'b1;
        4'h1: return 1'b0;
        4'h2: return !(c || z);
        4'h3: return c || z;
        4'h4: return !c;
        4'h5: return c;
        4'h6: return !z;
        4'h7: return z;
        4'h8: return !v;
        4'h9: return v;
        4'ha: return !n;
        4'hb: return n;
        4'hc: return !(n ^ v);
        4'hd: return n ^ v;
        4'he: return !(z || (n ^ v));
        default: return z || (n ^ v);
    endcase
endfunction

// expected byte strobes of one push or pull
task automatic stack_model(input logic [7:0] o, input logic [7:0] pb);
    logic pull;
    logic u;
    pull = (o == `OP_PULS) || (o == `OP_PULU);
    u    = (o == `OP_PSHU) || (o == `OP_PULU);
    if (!pull) begin
        for (int b = 7; b >= 0; b--) begin
            if (pb[b] && b >= `PB_X)
                exp_q.push_back({1'b0, u, 1'b1, 3'(b)});
            if (pb[b])
                exp_q.push_back({1'b0, u, 1'b0, 3'(b)});
        end
    end else begin
        for (int b = 0; b < 8; b++) begin
            if (pb[b])
                exp_q.push_back({1'b1, u, 1'b0, 3'(b)});
            if (pb[b] && b >= `PB_X)
                exp_q.push_back({1'b1, u, 1'b1, 3'(b)});
        end
    end
endtask

task automatic start_op(input logic [7:0] o, input logic [7:0] pb,
                        input logic [15:0] d, input logic [7:0] f);
    if (o[7:4] == `OP_BCC_HI) begin
        exp_pc = exp_pc + 16'd2;
        if (taken_ref(o, f))
            exp_pc = exp_pc + {{8{d[7]}}, d[7:0]};
    end else if (o == `OP_JMP) begin
        exp_pc = d;
    end else if (o == `OP_PSHS || o == `OP_PULS || o == `OP_PSHU || o == `OP_PULU) begin
        stack_model(o, pb);
        exp_pc = exp_pc + 16'd2;
    end else begin
        exp_pc = exp_pc + 16'd1;
    end
    ni_base = ni_count;
    @(posedge clk);
    op_ld    <= 1'b1;
    op       <= o;
    postbyte <= pb;
    data     <= d;
    cc       <= f;
    @(posedge clk);
    op_ld <= 1'b0;
endtask

task automatic wait_ni();
    while (ni_count == ni_base)
        @(negedge clk);
endtask

task automatic run_op(input logic [7:0] o, input logic [7:0] pb,
                      input logic [15:0] d, input logic [7:0] f);
    start_op(o, pb, d, f);
    wait_ni();
endtask

always @(posedge clk) begin
    stk_step <= cen && !halt && !rst;
    cpu_step <= cen && !rst;
    was_rst  <= rst;
end

// outputs are stable at the falling edge
always @(negedge clk) begin : monitor
    logic [5:0] e;
    cur_out = {pc, stk_wr, stk_rd, 3'(stk_reg), stk_hi, stk_u};
    if (dut0.chk0.err_count != 0)
        die("a protocol assertion in the checker fired");
    if (stk_step && (stk_wr || stk_rd)) begin
        if (exp_q.size() == 0)
            die("a stack strobe came when none was expected");
        e = exp_q.pop_front();
        assert ({stk_rd, stk_u, stk_hi, 3'(stk_reg)} == e)
            else mismatch("{stk_rd,stk_u,stk_hi,stk_reg}", e,
                          {stk_rd, stk_u, stk_hi, 3'(stk_reg)});
    end
    // frozen cycle, nothing may move
    if (!stk_step && !was_rst && !$isunknown(prev_out))
        assert (cur_out == prev_out)
            else mismatch("frozen {pc,strobes}", prev_out, cur_out);
    if (cpu_step && ni) begin
        ni_count++;
        assert (pc == exp_pc) else mismatch("pc", exp_pc, pc);
        if (exp_q.size() != 0)
            die("ni arrived with stack strobes still missing");
    end
    prev_out = cur_out;
end

initial begin : watchdog
    #(TIMEOUT);
    die("timeout, ni never arrived");
end

initial begin : stimulus
    logic [31:0] r1;
    logic [31:0] r2;
    logic [7:0]  stk_ops[4];
    rst      = 1'b1;
    cen      = 1'b1;
    op_ld    = 1'b0;
    op       = `OP_NOP;
    postbyte = 8'd0;
    data     = '0;
    cc       = 8'd0;
    halt     = 1'b0;
    stk_step = 1'b0;
    cpu_step = 1'b0;
    was_rst  = 1'b0;
    exp_pc   = '0;
    stk_ops  = '{`OP_PSHS, `OP_PULS, `OP_PSHU, `OP_PULU};
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // nop run
    repeat (8)
        run_op(`OP_NOP, 8'd0, 16'd0, 8'd0);

    // every condition twice, random flags and offsets
    for (int k = 0; k < 32; k++) begin
        take_bits(16, r1);
        take_bits(8, r2);
        run_op({`OP_BCC_HI, 4'(k)}, 8'd0, r1[15:0], r2[7:0]);
    end

    repeat (2) begin
        take_bits(16, r1);
        run_op(`OP_JMP, 8'd0, r1[15:0], 8'd0);
    end

    // empty, full and random register lists
    foreach (stk_ops[i]) begin
        run_op(stk_ops[i], 8'h00, 16'd0, 8'd0);
        run_op(stk_ops[i], 8'hff, 16'd0, 8'd0);
        repeat (4) begin
            take_bits(8, r1);
            run_op(stk_ops[i], r1[7:0], 16'd0, 8'd0);
        end
    end

    // op_ld again while the push runs, then halt, then cen low
    start_op(`OP_PSHS, 8'hff, 16'd0, 8'd0);
    @(posedge clk);
    op_ld <= 1'b1;
    repeat (3) @(posedge clk);
    op_ld <= 1'b0;
    halt  <= 1'b1;
    repeat (3) @(posedge clk);
    halt <= 1'b0;
    cen  <= 1'b0;
    repeat (3) @(posedge clk);
    cen <= 1'b1;
    wait_ni();

    // op_ld offered to an idle, halted sequencer
    @(posedge clk);
    halt  <= 1'b1;
    op_ld <= 1'b1;
    op    <= `OP_NOP;
    repeat (4) @(posedge clk);
    halt  <= 1'b0;
    op_ld <= 1'b0;
    run_op(`OP_NOP, 8'd0, 16'd0, 8'd0);

    // reset during a pull
    start_op(`OP_PULS, 8'hff, 16'd0, 8'd0);
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    exp_q.delete();
    exp_pc = '0;
    rst <= 1'b0;
    @(negedge clk);
    assert (pc == '0) else mismatch("pc", 32'd0, pc);
    assert (!stk_wr && !stk_rd && !ni)
        else mismatch("{stk_wr,stk_rd,ni}", 32'd0, {stk_wr, stk_rd, ni});
    run_op(`OP_NOP, 8'd0, 16'd0, 8'd0);

    repeat (2) @(posedge clk);
    if (dut0.chk0.err_count == 0 && exp_q.size() == 0) begin
        $display("TEST OK");
        $finish;
    end else begin
        die("checker errors or unmatched strobes at the end of the run");
    end
end

endmodule

// File: verilog/branch_cond.sv
// short branch condition evaluator
// purely combinational, valid whenever op holds a bcc opcode
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module branch_cond(
    input        [7:0] op,
    input        [7:0] cc,
    output logic       taken
);

logic c;
logic v;
logic z;
logic n;
logic nxv;
// condition for the odd opcode of each pair
logic term;

assign c   = cc[`CC_C];
assign v   = cc[`CC_V];
assign z   = cc[`CC_Z];
assign n   = cc[`CC_N];
// signed compare result
assign nxv = n ^ v;

// op[3:1] picks the pair
always_comb begin
    case (op[3:1])
        // bra / brn
        3'd0: term = 1'b0;
        // bhi / bls, unsigned above
        3'd1: term = c | z;
        // bcc / bcs
        3'd2: term = c;
        // bne / beq
        3'd3: term = z;
        // bvc / bvs
        3'd4: term = v;
        // bpl / bmi
        3'd5: term = n;
        // bge / blt
        3'd6: term = nxv;
        // bgt / ble
        default: term = z | nxv;
    endcase
end

// even opcodes take the inverted term
// so bra gets always and brn never
assign taken = op[0] ? term : ~term;

endmodule

// File: verilog/ctrl_defs.svh
// opcode encodings, pc width and postbyte bit positions
// include wherever one of these constants is needed
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// program counter width
`define CTRL_PC_W 16

// supported opcodes
`define OP_NOP  8'h12
`define OP_JMP  8'h7e
`define OP_PSHS 8'h34
`define OP_PULS 8'h35
`define OP_PSHU 8'h36
`define OP_PULU 8'h37

// upper nibble of all short branches, 0x20..0x2f
`define OP_BCC_HI 4'h2

// opcode bit that picks the u stack in push/pull
`define OP_STK_U_BIT 1

// condition code flag positions
`define CC_C 0
`define CC_V 1
`define CC_Z 2
`define CC_N 3

// push/pull postbyte bits
`define PB_CC 0
`define PB_A  1
`define PB_B  2
`define PB_DP 3
// first 16-bit register, everything from here up is two bytes
`define PB_X  4
`define PB_Y  5
`define PB_US 6
`define PB_PC 7

`endif

// File: verilog/ctrl_pkg.sv
// shared types for the instruction control slice
// imported by the sequencer, the stack stepper and the pc unit
package ctrl_pkg;

    // microcode sequencer states
    // done is the single cycle where ni is high
    typedef enum logic [2:0] {
        USEQ_IDLE     = 3'd0,
        USEQ_DISPATCH = 3'd1,
        USEQ_BRANCH   = 3'd2,
        USEQ_JUMP     = 3'd3,
        USEQ_STACK    = 3'd4,
        USEQ_DONE     = 3'd5
    } useq_state_t;

    // pc action applied on one enabled edge
    typedef enum logic [2:0] {
        PC_HOLD = 3'd0,
        PC_INC1 = 3'd1,
        PC_INC2 = 3'd2,
        // pc+2 plus signed 8-bit offset
        PC_REL  = 3'd3,
        PC_ABS  = 3'd4
    } pc_op_t;

    // stack byte register select
    // same order as the push/pull postbyte bits
    typedef enum logic [2:0] {
        STK_CC = 3'd0,
        STK_A  = 3'd1,
        STK_B  = 3'd2,
        STK_DP = 3'd3,
        STK_X  = 3'd4,
        STK_Y  = 3'd5,
        // u for pshs/puls, s for pshu/pulu
        STK_US = 3'd6,
        STK_PC = 3'd7
    } stk_reg_t;

endpackage

// File: verilog/ctrl_top.sv
// top of the instruction control slice
// op, postbyte, data and cc stay on their buses from op_ld until ni
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module ctrl_top(
    input                            clk,
    input                            rst,
    input                            cen,
    input                            op_ld,
    input        [7:0]               op,
    input        [7:0]               postbyte,
    input        [`CTRL_PC_W-1:0]    data,
    input        [7:0]               cc,
    input                            halt,
    output logic [`CTRL_PC_W-1:0]    pc,
    output logic                     ni,
    output logic                     busy,
    output logic                     stk_wr,
    output logic                     stk_rd,
    output ctrl_pkg::stk_reg_t       stk_reg,
    output logic                     stk_hi,
    output logic                     stk_u
);

import ctrl_pkg::*;

pc_op_t pc_op;
logic   taken;
logic   psh_go;
logic   pul_go;
logic   stk_busy;
// halt freezes the stepper too, strobes hold their level
logic   stk_cen;

assign stk_cen = cen & ~halt;

ucode_seq u_ucode(
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cen        ( cen        ),
    .op_ld      ( op_ld      ),
    .op         ( op         ),
    .halt       ( halt       ),
    .taken      ( taken      ),
    .stk_busy   ( stk_busy   ),
    .busy       ( busy       ),
    .ni         ( ni         ),
    .psh_go     ( psh_go     ),
    .pul_go     ( pul_go     ),
    .pc_op      ( pc_op      )
);

branch_cond u_branch(
    .op         ( op         ),
    .cc         ( cc         ),
    .taken      ( taken      )
);

pshpul_seq u_pshpul(
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cen        ( stk_cen    ),
    .psh_go     ( psh_go     ),
    .pul_go     ( pul_go     ),
    .op         ( op         ),
    .postbyte   ( postbyte   ),
    .stk_busy   ( stk_busy   ),
    .stk_wr     ( stk_wr     ),
    .stk_rd     ( stk_rd     ),
    .stk_reg    ( stk_reg    ),
    .stk_hi     ( stk_hi     ),
    .stk_u      ( stk_u      )
);

pc_unit u_pc(
    .clk        ( clk        ),
    .rst        ( rst        ),
    .cen        ( cen        ),
    .pc_op      ( pc_op      ),
    .data       ( data       ),
    .pc         ( pc         )
);

endmodule

// File: verilog/pc_unit.sv
// program counter register
// applies the pc action requested by the sequencer on each enabled edge
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module pc_unit(
    input                             clk,
    input                             rst,
    input                             cen,
    input  ctrl_pkg::pc_op_t          pc_op,
    input  logic [`CTRL_PC_W-1:0]     data,
    output logic [`CTRL_PC_W-1:0]     pc
);

import ctrl_pkg::*;

logic [`CTRL_PC_W-1:0] pc_inc1;
logic [`CTRL_PC_W-1:0] pc_inc2;
// sign-extended branch offset from data low byte
logic [`CTRL_PC_W-1:0] offset;
logic [`CTRL_PC_W-1:0] pc_rel;

assign pc_inc1 = pc + `CTRL_PC_W'(1);
assign pc_inc2 = pc + `CTRL_PC_W'(2);
assign offset  = {{(`CTRL_PC_W-8){data[7]}}, data[7:0]};
// bcc target is relative to the byte after the instruction
assign pc_rel  = pc_inc2 + offset;

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= '0;
    end else if (cen) begin
        case (pc_op)
            PC_INC1: pc <= pc_inc1;
            PC_INC2: pc <= pc_inc2;
            PC_REL:  pc <= pc_rel;
            // jmp extended, full target on data
            PC_ABS:  pc <= data;
            default: pc <= pc;
        endcase
    end
end

endmodule

// File: verilog/pshpul_seq.sv
// push/pull register list stepper
// started by psh_go or pul_go, emits one stack byte strobe per enabled cycle
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module pshpul_seq(
    input                      clk,
    input                      rst,
    input                      cen,
    input                      psh_go,
    input                      pul_go,
    input                [7:0] op,
    input                [7:0] postbyte,
    output logic               stk_busy,
    output logic               stk_wr,
    output logic               stk_rd,
    output ctrl_pkg::stk_reg_t stk_reg,
    output logic               stk_hi,
    output logic               stk_u
);

import ctrl_pkg::*;

// registers still to be moved
logic [7:0] mask;
// direction, set for pull
logic       pull;
// first byte of a 16-bit register already sent
logic       second;
// bit picked this cycle
logic [2:0] sel;
logic       wide;

assign stk_busy = |mask;
assign wide     = sel >= 3'(`PB_X);

// push walks 7 down to 0, pull walks 0 up to 7
// last match in the loop wins
always_comb begin
    sel = 3'd0;
    if (pull) begin
        for (int i = 7; i >= 0; i--) begin
            if (mask[i])
                sel = 3'(i);
        end
    end else begin
        for (int i = 0; i < 8; i++) begin
            if (mask[i])
                sel = 3'(i);
        end
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        mask   <= 8'd0;
        pull   <= 1'b0;
        second <= 1'b0;
        stk_wr <= 1'b0;
        stk_rd <= 1'b0;
        stk_u  <= 1'b0;
    end else if (cen) begin
        if (psh_go || pul_go) begin
            // new list, nothing strobed on this edge
            mask   <= postbyte;
            pull   <= pul_go;
            stk_u  <= op[`OP_STK_U_BIT];
            second <= 1'b0;
            stk_wr <= 1'b0;
            stk_rd <= 1'b0;
        end else if (stk_busy) begin
            stk_wr  <= ~pull;
            stk_rd  <= pull;
            stk_reg <= stk_reg_t'(sel);
            // push sends high then low, pull low then high
            stk_hi  <= wide & (pull ? second : ~second);
            if (wide && !second) begin
                second <= 1'b1;
            end else begin
                // register done, drop its bit
                mask[sel] <= 1'b0;
                second    <= 1'b0;
            end
        end else begin
            stk_wr <= 1'b0;
            stk_rd <= 1'b0;
        end
    end
end

endmodule

// File: verilog/ucode_seq.sv
// microcode sequencer for nop, bcc, jmp and the push/pull family
// takes an opcode on op_ld, drives the pc action and pulses ni at the end
`timescale 1ns/100ps

`include "ctrl_defs.svh"

module ucode_seq(
    input                    clk,
    input                    rst,
    input                    cen,
    input                    op_ld,
    input              [7:0] op,
    input                    halt,
    input                    taken,
    input                    stk_busy,
    output logic             busy,
    output logic             ni,
    output logic             psh_go,
    output logic             pul_go,
    output ctrl_pkg::pc_op_t pc_op
);

import ctrl_pkg::*;

useq_state_t state;
useq_state_t state_nx;
// opcode captured at acceptance
logic [7:0]  op_q;
logic        accept;
logic        is_bcc;
logic        is_jmp;
logic        is_psh;
logic        is_pul;

// class decode on the latched opcode
assign is_bcc = op_q[7:4] == `OP_BCC_HI;
assign is_jmp = op_q == `OP_JMP;
assign is_psh = op_q == `OP_PSHS || op_q == `OP_PSHU;
assign is_pul = op_q == `OP_PULS || op_q == `OP_PULU;

// done is the ni cycle and can already take the next opcode
assign busy   = state != USEQ_IDLE && state != USEQ_DONE;
assign ni     = state == USEQ_DONE;
assign accept = op_ld && !busy && !halt;

always_comb begin
    state_nx = state;
    pc_op    = PC_HOLD;
    psh_go   = 1'b0;
    pul_go   = 1'b0;
    case (state)
        USEQ_IDLE: begin
            if (accept)
                state_nx = USEQ_DISPATCH;
        end
        USEQ_DONE: begin
            // never linger here, ni lasts one cycle
            state_nx = accept ? USEQ_DISPATCH : USEQ_IDLE;
        end
        USEQ_DISPATCH: begin
            // halt freezes the instruction where it is
            if (!halt) begin
                if (is_bcc) begin
                    state_nx = USEQ_BRANCH;
                end else if (is_jmp) begin
                    state_nx = USEQ_JUMP;
                end else if (is_psh) begin
                    psh_go   = 1'b1;
                    state_nx = USEQ_STACK;
                end else if (is_pul) begin
                    pul_go   = 1'b1;
                    state_nx = USEQ_STACK;
                end else begin
                    // nop and anything unknown, one byte
                    pc_op    = PC_INC1;
                    state_nx = USEQ_DONE;
                end
            end
        end
        USEQ_BRANCH: begin
            if (!halt) begin
                pc_op    = taken ? PC_REL : PC_INC2;
                state_nx = USEQ_DONE;
            end
        end
        USEQ_JUMP: begin
            if (!halt) begin
                pc_op    = PC_ABS;
                state_nx = USEQ_DONE;
            end
        end
        USEQ_STACK: begin
            // wait for the stepper to drain its list
            if (!halt && !stk_busy) begin
                pc_op    = PC_INC2;
                state_nx = USEQ_DONE;
            end
        end
        default: state_nx = USEQ_IDLE;
    endcase
end

always_ff @(posedge clk) begin
    if (rst)
        state <= USEQ_IDLE;
    else if (cen)
        state <= state_nx;
end

always_ff @(posedge clk) begin
    if (cen && accept)
        op_q <= op;
end

endmodule
